//--- include/vc_router_settings.svh
/*
 * Virtual-channel router settings
 * Port count, VCs per port, FIFO depth and payload width shared by the
 * package and the RTL
 */

`ifndef VC_ROUTER_SETTINGS_SVH
`define VC_ROUTER_SETTINGS_SVH

// physical ports, each one both input and output
`define VR_NUM_PORTS 4

// virtual channels per port
`define VR_NUM_VC 2

// flits per VC FIFO, also the starting credit of each output VC
`define VR_VC_DEPTH 2

`define VR_PAYLOAD_W 16

`endif

//--- source/vc_router_pkg.sv
/*
 * Virtual-channel router package
 * Index, mask, counter and flit types used across the router
 */

`include "vc_router_settings.svh"

package vc_router_pkg;

  // index of a physical port
  typedef logic [$clog2(`VR_NUM_PORTS)-1:0] port_id_t;

  // index of a virtual channel
  typedef logic [$clog2(`VR_NUM_VC)-1:0] vc_id_t;

  typedef logic [`VR_NUM_PORTS-1:0] port_mask_t;
  typedef logic [`VR_NUM_VC-1:0]    vc_mask_t;

  // single-flit packet, the output port index is carried directly
  typedef struct packed {
    vc_id_t                   vc_id;
    port_id_t                 dst;
    logic [`VR_PAYLOAD_W-1:0] payload;
  } flit_t;

  // counts from 0 up to the VC depth
  typedef logic [$clog2(`VR_VC_DEPTH+1)-1:0] credit_cnt_t;

endpackage

//--- source/alloc_grant_if.sv
/*
 * Allocation result bundle
 * Per-output grants and per-input pops from switch allocation
 */

`timescale 1ns/1ps
`include "vc_router_settings.svh"

interface alloc_grant_if import vc_router_pkg::*; ();

  // per output
  port_mask_t                        grant_v;
  port_id_t [`VR_NUM_PORTS-1:0]      grant_in;
  vc_id_t   [`VR_NUM_PORTS-1:0]      grant_out_vc;

  // per input
  port_mask_t                        pop_v;
  vc_id_t   [`VR_NUM_PORTS-1:0]      pop_vc;

  modport alloc  (output grant_v, output grant_in, output grant_out_vc,
                  output pop_v, output pop_vc);
  modport trav   (input grant_v, input grant_in, input grant_out_vc,
                  input pop_v, input pop_vc);
  modport credit (input grant_v, input grant_out_vc);
  modport buffer (input pop_v, input pop_vc);

endinterface

//--- source/input_unit.sv
/*
 * Input unit
 * One circular FIFO per VC, written by the flit's own VC field; each
 * non-empty FIFO presents its head flit to switch allocation
 */

`timescale 1ns/1ps
`include "vc_router_settings.svh"

module input_unit import vc_router_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    data_v_i,
  input  flit_t                   data_i,
  output vc_mask_t                head_v_o,
  output flit_t [`VR_NUM_VC-1:0]  head_o,
  input  logic                    pop_v_i,
  input  vc_id_t                  pop_vc_i
);

  localparam int PTR_W = $clog2(`VR_VC_DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;

  flit_t                        mem [`VR_NUM_VC][`VR_VC_DEPTH];
  ptr_t        [`VR_NUM_VC-1:0] wr_ptr_q;
  ptr_t        [`VR_NUM_VC-1:0] rd_ptr_q;
  credit_cnt_t [`VR_NUM_VC-1:0] cnt_q;
  vc_mask_t                     push;
  vc_mask_t                     pop;

  // circular pointer step
  function automatic ptr_t ptr_inc(input ptr_t ptr);
    return (ptr == ptr_t'(`VR_VC_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_comb begin
    for (int v = 0; v < `VR_NUM_VC; v++) begin
      push[v] = data_v_i && (data_i.vc_id == vc_id_t'(v));
      pop[v]  = pop_v_i && (pop_vc_i == vc_id_t'(v));
    end
  end

  always_ff @(posedge clk_i) begin
    if (data_v_i) begin
      mem[data_i.vc_id][wr_ptr_q[data_i.vc_id]] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      for (int v = 0; v < `VR_NUM_VC; v++) begin
        if (push[v]) begin
          wr_ptr_q[v] <= ptr_inc(wr_ptr_q[v]);
        end
        if (pop[v]) begin
          rd_ptr_q[v] <= ptr_inc(rd_ptr_q[v]);
        end
        // push and pop together leave the fill level alone
        if (push[v] && !pop[v]) begin
          cnt_q[v] <= cnt_q[v] + 1'b1;
        end else if (pop[v] && !push[v]) begin
          cnt_q[v] <= cnt_q[v] - 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int v = 0; v < `VR_NUM_VC; v++) begin
      head_v_o[v] = (cnt_q[v] != '0);
      head_o[v]   = mem[v][rd_ptr_q[v]];
    end
  end

endmodule

//--- source/credit_tracker.sv
/*
 * Downstream credit tracker
 * One counter per output VC, consumed by grants and refilled by
 * credits returned from the next hop
 */

`timescale 1ns/1ps
`include "vc_router_settings.svh"

module credit_tracker import vc_router_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  port_mask_t                         credit_v_i,
  input  vc_id_t   [`VR_NUM_PORTS-1:0]       credit_id_i,
  alloc_grant_if.credit                      grant,
  output vc_mask_t [`VR_NUM_PORTS-1:0]       vc_free_o
);

  credit_cnt_t [`VR_NUM_PORTS-1:0][`VR_NUM_VC-1:0] cnt_q;
  logic        [`VR_NUM_PORTS-1:0][`VR_NUM_VC-1:0] take;
  logic        [`VR_NUM_PORTS-1:0][`VR_NUM_VC-1:0] give;

  always_comb begin
    for (int p = 0; p < `VR_NUM_PORTS; p++) begin
      for (int v = 0; v < `VR_NUM_VC; v++) begin
        take[p][v] = grant.grant_v[p] && (grant.grant_out_vc[p] == vc_id_t'(v));
        give[p][v] = credit_v_i[p] && (credit_id_i[p] == vc_id_t'(v));
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int p = 0; p < `VR_NUM_PORTS; p++) begin
        for (int v = 0; v < `VR_NUM_VC; v++) begin
          cnt_q[p][v] <= credit_cnt_t'(`VR_VC_DEPTH);
        end
      end
    end else begin
      for (int p = 0; p < `VR_NUM_PORTS; p++) begin
        for (int v = 0; v < `VR_NUM_VC; v++) begin
          // a grant and a returned credit in the same cycle cancel out
          if (take[p][v] && !give[p][v]) begin
            cnt_q[p][v] <= cnt_q[p][v] - 1'b1;
          end else if (give[p][v] && !take[p][v]) begin
            cnt_q[p][v] <= cnt_q[p][v] + 1'b1;
          end
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < `VR_NUM_PORTS; p++) begin
      for (int v = 0; v < `VR_NUM_VC; v++) begin
        vc_free_o[p][v] = (cnt_q[p][v] != '0);
      end
    end
  end

endmodule

//--- source/switch_alloc.sv
/*
 * Switch allocator
 * Round-robin VC pick per input, round-robin input pick per output,
 * then the lowest output VC with credit is assigned to the winner
 */

`timescale 1ns/1ps
`include "vc_router_settings.svh"

module switch_alloc import vc_router_pkg::*; (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  vc_mask_t [`VR_NUM_PORTS-1:0]                  head_v_i,
  input  flit_t    [`VR_NUM_PORTS-1:0][`VR_NUM_VC-1:0]  head_i,
  input  vc_mask_t [`VR_NUM_PORTS-1:0]                  vc_free_i,
  alloc_grant_if.alloc                                  grant
);

  vc_mask_t   [`VR_NUM_PORTS-1:0] vc_req;
  port_mask_t                     local_v;
  vc_id_t     [`VR_NUM_PORTS-1:0] local_vc;
  port_id_t   [`VR_NUM_PORTS-1:0] local_dst;
  port_mask_t [`VR_NUM_PORTS-1:0] in_req;
  port_mask_t                     out_v;
  port_id_t   [`VR_NUM_PORTS-1:0] out_in;
  vc_id_t     [`VR_NUM_PORTS-1:0] out_vc;
  port_mask_t                     pop_v;
  vc_id_t     [`VR_NUM_PORTS-1:0] lrr_q;
  port_id_t   [`VR_NUM_PORTS-1:0] grr_q;

  function automatic vc_id_t vc_wrap(input int base, input int off);
    return vc_id_t'((base + off) % `VR_NUM_VC);
  endfunction

  function automatic port_id_t port_wrap(input int base, input int off);
    return port_id_t'((base + off) % `VR_NUM_PORTS);
  endfunction

  // ====================================================================
  // local stage: one VC per input
  // ====================================================================

  always_comb begin
    for (int i = 0; i < `VR_NUM_PORTS; i++) begin
      // a VC only requests if its output has some credit left
      for (int v = 0; v < `VR_NUM_VC; v++) begin
        vc_req[i][v] = head_v_i[i][v] && (|vc_free_i[head_i[i][v].dst]);
      end
      local_v[i]  = 1'b0;
      local_vc[i] = lrr_q[i];
      for (int k = 0; k < `VR_NUM_VC; k++) begin
        if (!local_v[i] && vc_req[i][vc_wrap(lrr_q[i], k)]) begin
          local_v[i]  = 1'b1;
          local_vc[i] = vc_wrap(lrr_q[i], k);
        end
      end
      local_dst[i] = head_i[i][local_vc[i]].dst;
    end
  end

  // ====================================================================
  // global stage: one input per output, plus VC assignment
  // ====================================================================

  always_comb begin
    for (int o = 0; o < `VR_NUM_PORTS; o++) begin
      for (int i = 0; i < `VR_NUM_PORTS; i++) begin
        in_req[o][i] = local_v[i] && (local_dst[i] == port_id_t'(o));
      end
      out_v[o]  = 1'b0;
      out_in[o] = grr_q[o];
      for (int k = 0; k < `VR_NUM_PORTS; k++) begin
        if (!out_v[o] && in_req[o][port_wrap(grr_q[o], k)]) begin
          out_v[o]  = 1'b1;
          out_in[o] = port_wrap(grr_q[o], k);
        end
      end
      // lowest free VC wins
      out_vc[o] = '0;
      for (int v = `VR_NUM_VC - 1; v >= 0; v--) begin
        if (vc_free_i[o][v]) begin
          out_vc[o] = vc_id_t'(v);
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `VR_NUM_PORTS; i++) begin
      pop_v[i] = local_v[i] && out_v[local_dst[i]] &&
                 (out_in[local_dst[i]] == port_id_t'(i));
    end
  end

  assign grant.grant_v      = out_v;
  assign grant.grant_in     = out_in;
  assign grant.grant_out_vc = out_vc;
  assign grant.pop_v        = pop_v;
  assign grant.pop_vc       = local_vc;

  // pointers move past a winner only once it is actually served
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lrr_q <= '0;
      grr_q <= '0;
    end else begin
      for (int i = 0; i < `VR_NUM_PORTS; i++) begin
        if (pop_v[i]) begin
          lrr_q[i] <= vc_wrap(local_vc[i], 1);
        end
        if (out_v[i]) begin
          grr_q[i] <= port_wrap(out_in[i], 1);
        end
      end
    end
  end

endmodule

//--- source/switch_traversal.sv
/*
 * Switch traversal stage
 * Crossbar from the popped heads to the outputs, registered together
 * with the upstream credit returns
 */

`timescale 1ns/1ps
`include "vc_router_settings.svh"

module switch_traversal import vc_router_pkg::*; (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  alloc_grant_if.trav                                   grant,
  input  flit_t    [`VR_NUM_PORTS-1:0][`VR_NUM_VC-1:0]  head_i,
  output port_mask_t                                    data_v_o,
  output flit_t    [`VR_NUM_PORTS-1:0]                  data_o,
  output port_mask_t                                    credit_v_o,
  output vc_id_t   [`VR_NUM_PORTS-1:0]                  credit_id_o
);

  flit_t [`VR_NUM_PORTS-1:0] st_flit;

  // pick the winning input's popped VC and tag it with the new VC
  always_comb begin
    for (int o = 0; o < `VR_NUM_PORTS; o++) begin
      st_flit[o]       = head_i[grant.grant_in[o]][grant.pop_vc[grant.grant_in[o]]];
      st_flit[o].vc_id = grant.grant_out_vc[o];
    end
  end

  always_ff @(posedge clk_i) begin
    data_o      <= st_flit;
    credit_id_o <= grant.pop_vc;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      data_v_o   <= '0;
      credit_v_o <= '0;
    end else begin
      data_v_o   <= grant.grant_v;
      credit_v_o <= grant.pop_v;
    end
  end

endmodule

//--- source/vc_router.sv
/*
 * Virtual-channel router top level
 * Input buffering, switch allocation and switch traversal for four
 * ports with two VCs each
 */

`timescale 1ns/1ps
`include "vc_router_settings.svh"

module vc_router import vc_router_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // upstream side
  input  port_mask_t                       data_v_i,
  input  flit_t    [`VR_NUM_PORTS-1:0]     data_i,
  output port_mask_t                       credit_v_o,
  output vc_id_t   [`VR_NUM_PORTS-1:0]     credit_id_o,
  // downstream side
  input  port_mask_t                       credit_v_i,
  input  vc_id_t   [`VR_NUM_PORTS-1:0]     credit_id_i,
  output port_mask_t                       data_v_o,
  output flit_t    [`VR_NUM_PORTS-1:0]     data_o
);

  vc_mask_t [`VR_NUM_PORTS-1:0]                  head_v;
  flit_t    [`VR_NUM_PORTS-1:0][`VR_NUM_VC-1:0]  head;
  vc_mask_t [`VR_NUM_PORTS-1:0]                  vc_free;

  alloc_grant_if u_grant ();

  // ====================================================================
  // input buffering
  // ====================================================================

  for (genvar g = 0; g < `VR_NUM_PORTS; g++) begin : gen_input
    input_unit u_input (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .data_v_i (data_v_i[g]),
      .data_i   (data_i[g]),
      .head_v_o (head_v[g]),
      .head_o   (head[g]),
      .pop_v_i  (u_grant.pop_v[g]),
      .pop_vc_i (u_grant.pop_vc[g])
    );
  end

  credit_tracker u_credit (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i),
    .grant       (u_grant.credit),
    .vc_free_o   (vc_free)
  );

  switch_alloc u_alloc (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .head_v_i  (head_v),
    .head_i    (head),
    .vc_free_i (vc_free),
    .grant     (u_grant.alloc)
  );

  switch_traversal u_trav (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .grant       (u_grant.trav),
    .head_i      (head),
    .data_v_o    (data_v_o),
    .data_o      (data_o),
    .credit_v_o  (credit_v_o),
    .credit_id_o (credit_id_o)
  );

endmodule

//--- tests/tb_vc_router.sv
/*
 * Virtual-channel router testbench
 * Directed tests with a scoreboard that predicts output VCs from its own
 * downstream credit model and checks flits and upstream credit returns
 */

`timescale 1ns/1ps
`include "vc_router_settings.svh"

module tb_vc_router import vc_router_pkg::*; ();

  logic                              clk_i;
  logic                              rst_n_i;
  port_mask_t                        data_v_i;
  flit_t      [`VR_NUM_PORTS-1:0]    data_i;
  port_mask_t                        credit_v_o;
  vc_id_t     [`VR_NUM_PORTS-1:0]    credit_id_o;
  port_mask_t                        credit_v_i;
  vc_id_t     [`VR_NUM_PORTS-1:0]    credit_id_i;
  port_mask_t                        data_v_o;
  flit_t      [`VR_NUM_PORTS-1:0]    data_o;

  int     errors = 0;
  int     seed;
  int     cycle = 0;
  // downstream credits per output VC as the next hop sees them
  int     down_cnt [`VR_NUM_PORTS][`VR_NUM_VC];
  flit_t  exp_flit [`VR_NUM_PORTS][$];
  vc_id_t exp_credit [`VR_NUM_PORTS][$];
  int     rx_cnt [`VR_NUM_PORTS];
  int     rx_cycle [`VR_NUM_PORTS];
  int     cr_cycle [`VR_NUM_PORTS];

  vc_router DUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .data_v_i    (data_v_i),
    .data_i      (data_i),
    .credit_v_o  (credit_v_o),
    .credit_id_o (credit_id_o),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i),
    .data_v_o    (data_v_o),
    .data_o      (data_o)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;
  always @(posedge clk_i) cycle <= cycle + 1;

  // ====================================================================
  // scoreboard sampled on the falling edge
  // ====================================================================

  // lowest output VC that still has downstream credit or -1 if none
  function automatic int lowest_credit(input int o);
    for (int v = 0; v < `VR_NUM_VC; v++) begin
      if (down_cnt[o][v] > 0) begin
        return v;
      end
    end
    return -1;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int p = 0; p < `VR_NUM_PORTS; p++) begin
      n += exp_flit[p].size() + exp_credit[p].size();
    end
    return n;
  endfunction

  always @(negedge clk_i) begin : scoreboard
    flit_t  want_flit;
    vc_id_t want_id;
    int     free_vc;
    if (rst_n_i) begin
      for (int p = 0; p < `VR_NUM_PORTS; p++) begin
        if (data_v_o[p]) begin
          rx_cnt[p]++;
          rx_cycle[p] = cycle;
          free_vc = lowest_credit(p);
          assert (exp_flit[p].size() > 0 && free_vc >= 0) else begin
            errors++;
            $display("Output %0d sent a flit that was not expected or had no credit", p);
          end
          if (exp_flit[p].size() > 0 && free_vc >= 0) begin
            want_flit       = exp_flit[p].pop_front();
            want_flit.vc_id = vc_id_t'(free_vc);
            down_cnt[p][free_vc]--;
            assert (data_o[p] === want_flit) else begin
              errors++;
              $display("Fail data_o[%0d]: expected %h, got %h", p, want_flit, data_o[p]);
            end
          end
        end
        if (credit_v_o[p]) begin
          cr_cycle[p] = cycle;
          assert (exp_credit[p].size() > 0) else begin
            errors++;
            $display("Input %0d returned a credit that was not expected", p);
          end
          if (exp_credit[p].size() > 0) begin
            want_id = exp_credit[p].pop_front();
            assert (credit_id_o[p] === want_id) else begin
              errors++;
              $display("Fail credit_id_o[%0d]: expected %h, got %h", p, want_id,
                       credit_id_o[p]);
            end
          end
        end
      end
    end
  end

  // ====================================================================
  // drive helpers entered 1 ns after a rising edge
  // ====================================================================

  task automatic step();
    @(posedge clk_i);
    #1;
    data_v_i   = '0;
    credit_v_i = '0;
  endtask

  task automatic reset_dut();
    rst_n_i    = 1'b0;
    data_v_i   = '0;
    credit_v_i = '0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    for (int p = 0; p < `VR_NUM_PORTS; p++) begin
      for (int v = 0; v < `VR_NUM_VC; v++) begin
        down_cnt[p][v] = `VR_VC_DEPTH;
      end
      exp_flit[p].delete();
      exp_credit[p].delete();
      rx_cnt[p]   = 0;
      rx_cycle[p] = -1;
      cr_cycle[p] = -1;
    end
  endtask

  // present one flit for the coming edge and record what should follow
  task automatic put_flit(input int p, input int vc, input int dst);
    flit_t f;
    f.vc_id     = vc_id_t'(vc);
    f.dst       = port_id_t'(dst);
    f.payload   = $random(seed);
    data_v_i[p] = 1'b1;
    data_i[p]   = f;
    exp_flit[dst].push_back(f);
    exp_credit[p].push_back(vc_id_t'(vc));
  endtask

  task automatic return_credit(input int o, input int vc);
    credit_v_i[o]  = 1'b1;
    credit_id_i[o] = vc_id_t'(vc);
    down_cnt[o][vc]++;
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (pending() > 0 && n < limit) begin
      step();
      n++;
    end
    assert (pending() == 0) else begin
      errors++;
      $display("Timeout after %0d cycles with %0d flits or credits outstanding", n,
               pending());
    end
  endtask

  // ====================================================================
  // directed tests
  // ====================================================================

  task automatic single_flit_test();
    int sent;
    reset_dut();
    put_flit(0, 1, 2);
    sent = cycle;
    step();
    wait_drain(20);
    assert (rx_cycle[2] == sent + 2) else begin
      errors++;
      $display("Fail data_v_o[2] cycle: expected %h, got %h", sent + 2, rx_cycle[2]);
    end
    assert (cr_cycle[0] == sent + 2) else begin
      errors++;
      $display("Fail credit_v_o[0] cycle: expected %h, got %h", sent + 2, cr_cycle[0]);
    end
  endtask

  task automatic parallel_test();
    int sent;
    reset_dut();
    put_flit(0, 0, 3);
    put_flit(1, 1, 2);
    sent = cycle;
    step();
    wait_drain(20);
    assert (rx_cycle[3] == sent + 2) else begin
      errors++;
      $display("Fail data_v_o[3] cycle: expected %h, got %h", sent + 2, rx_cycle[3]);
    end
    assert (rx_cycle[2] == sent + 2) else begin
      errors++;
      $display("Fail data_v_o[2] cycle: expected %h, got %h", sent + 2, rx_cycle[2]);
    end
  endtask

  // output 0 alternates between inputs 1 and 3 starting with input 1
  task automatic contention_test();
    reset_dut();
    put_flit(1, 0, 0);
    put_flit(3, 0, 0);
    step();
    put_flit(1, 0, 0);
    put_flit(3, 0, 0);
    step();
    wait_drain(30);
  endtask

  task automatic backpressure_test();
    int base;
    reset_dut();
    for (int k = 0; k < `VR_NUM_VC * `VR_VC_DEPTH; k++) begin
      put_flit(0, 0, 1);
      step();
    end
    wait_drain(30);
    put_flit(2, 0, 1);
    step();
    base = rx_cnt[1];
    repeat (20) step();
    assert (rx_cnt[1] == base) else begin
      errors++;
      $display("Output 1 sent a flit while it had no downstream credit");
    end
    return_credit(1, 0);
    step();
    wait_drain(20);
  endtask

  // input 0 wins output 0 first, so input 2 holds flits on both VCs
  task automatic vc_buffer_test();
    reset_dut();
    put_flit(0, 0, 0);
    put_flit(2, 0, 0);
    step();
    put_flit(2, 1, 3);
    step();
    wait_drain(20);
  endtask

  initial begin
    seed        = 86284;
    rst_n_i     = 1'b0;
    data_v_i    = '0;
    data_i      = '0;
    credit_v_i  = '0;
    credit_id_i = '0;
    single_flit_test();
    parallel_test();
    contention_test();
    backpressure_test();
    vc_buffer_test();
    $display("Checks complete with %0d errors", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- vc_router.f
+incdir+include
source/vc_router_pkg.sv
source/alloc_grant_if.sv
source/input_unit.sv
source/credit_tracker.sv
source/switch_alloc.sv
source/switch_traversal.sv
source/vc_router.sv
tests/tb_vc_router.sv

//--- Bender.yml
package:
  name: vc_router

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/vc_router_pkg.sv
      - source/alloc_grant_if.sv
      - source/input_unit.sv
      - source/credit_tracker.sv
      - source/switch_alloc.sv
      - source/switch_traversal.sv
      - source/vc_router.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_vc_router.sv
